// File: all.f
zorro_pkg.sv
autocfg_pkg.sv
z3_bus_sync.sv
z3_slave_fsm.sv
autocfg_regs.sv
card_ram.sv
z3_card_top.sv
z3_card_properties.sv
tb_z3_card.sv

// File: tb_z3_card.sv
// memory size fixed at 256 words here; card base written as 0x40000000 during autoconfig
`timescale 1ns/1ps

module tb_z3_card import zorro_pkg::*; ();
	localparam logic [31:0] BASE_ADDR = 32'h4000_0000;
	localparam int NUM_BUS_CYCLES = 44;
	localparam int WATCHDOG_CYCLES = NUM_BUS_CYCLES * 60 + 3 * 20;

	logic        clk, nIORST, read_i, n_fcs_i, doe_i, n_cfgin_i, sense_z3_i;
	logic [7:2]  a_i;
	logic [1:0]  fc_i;
	logic [3:0]  n_ds_i;
	z3_lanes_t   bus_in, bus_out;
	logic        lanes_oe_o, n_slave_o, n_dtack_o, n_cfgout_o;
	logic [31:0] rng = 32'h412d;
	logic [31:0] model [256];

	z3_card_top #(.RAM_WORDS_LOG2(8)) z3_card_top_inst (
		.clk(clk), .nIORST(nIORST), .lanes_i(bus_in), .a_i(a_i), .fc_i(fc_i),
		.read_i(read_i), .n_fcs_i(n_fcs_i), .doe_i(doe_i), .n_ds_i(n_ds_i),
		.n_cfgin_i(n_cfgin_i), .sense_z3_i(sense_z3_i), .lanes_o(bus_out),
		.lanes_oe_o(lanes_oe_o), .n_slave_o(n_slave_o), .n_dtack_o(n_dtack_o),
		.n_cfgout_o(n_cfgout_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// reference model and random source
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// TYPE reads true, all others inverted, unknown offsets as nibble 0
	function automatic logic [3:0] ref_cfg_nibble(input logic [7:0] off);
		case (off)
			8'h00: return 4'h8;
			8'h04: return ~4'h3;
			8'h08: return ~4'h3;
			8'h10: return ~4'hA;
			8'h14: return ~4'hB;
			default: return ~4'h0;
		endcase
	endfunction

	// be bit 3 covers bits 31:24
	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (be[b])
				res[b*8 +: 8] = data[b*8 +: 8];
		return res;
	endfunction

	// contiguous run of 1 to 4 bytes
	function automatic logic [3:0] rand_mask(input logic [31:0] r);
		int len, pos;
		len = 1 + int'(r % 4);
		pos = int'((r >> 4) % (5 - len));
		return 4'(((1 << len) - 1) << pos);
	endfunction

	// high bit 10 set aliases onto the same word
	function automatic logic [31:0] card_addr(input logic [7:0] idx, input logic hi);
		return BASE_ADDR | {22'd0, idx, 2'b00} | (hi ? 32'h0000_0400 : 32'h0);
	endfunction

	// ------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------
	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_nibble(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	// ------------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------------
	task automatic bus_cycle(input logic [31:0] addr, input logic [1:0] fc, input logic rd,
			input logic [31:0] wword, input logic [3:0] be, input logic hit,
			output logic [31:0] rword);
		int n;
		z3_lanes_t got;
		// address phase
		@(posedge clk);
		#5;
		bus_in.ad = addr[31:8];
		bus_in.sd = 8'h00;
		a_i = addr[7:2];
		fc_i = fc;
		read_i = rd;
		@(posedge clk);
		#5;
		n_fcs_i = 1'b0;
		// address held 4 clocks, slave due by then
		repeat (4) @(posedge clk);
		#5;
		check_level(n_slave_o, !hit, "n_slave after address phase");
		doe_i = 1'b1;
		if (!rd) begin
			bus_in.ad = {wword[31:24], wword[15:0]};
			bus_in.sd = wword[23:16];
			n_ds_i = ~be;
		end
		rword = '0;
		if (hit) begin
			n = 0;
			while (n_dtack_o) begin
				@(posedge clk);
				#5;
				n++;
				if (n > 50) begin
					$display("No DTACK within 50 cycles for address %h", addr);
					stop_run();
				end
			end
			check_level(lanes_oe_o, rd, "lane enable at DTACK");
			got = bus_out;
			rword = {got.ad[31:24], got.sd, got.ad[23:8]};
		end else begin
			// nobody answers, master gives up
			repeat (20) begin
				@(posedge clk);
				#5;
				check_level(n_slave_o, 1'b1, "n_slave on ignored cycle");
				check_level(n_dtack_o, 1'b1, "n_dtack on ignored cycle");
			end
		end
		n_fcs_i = 1'b1;
		doe_i = 1'b0;
		n_ds_i = 4'hF;
		repeat (3) @(posedge clk);
		#5;
		check_level(n_slave_o, 1'b1, "n_slave after FCS release");
		check_level(n_dtack_o, 1'b1, "n_dtack after FCS release");
	endtask

	task automatic full_read(input logic [31:0] addr, input logic [1:0] fc, input logic hit,
			output logic [31:0] data);
		bus_cycle(addr, fc, 1'b1, 32'h0, 4'hF, hit, data);
	endtask

	task automatic full_write(input logic [31:0] addr, input logic [1:0] fc,
			input logic [31:0] data, input logic [3:0] be, input logic hit);
		logic [31:0] unused;
		bus_cycle(addr, fc, 1'b0, data, be, hit, unused);
	endtask

	task automatic apply_reset(input logic sense);
		nIORST = 1'b0;
		sense_z3_i = sense;
		repeat (16) @(posedge clk);
		#5;
		nIORST = 1'b1;
		check_level(n_slave_o, 1'b1, "n_slave after reset");
		check_level(n_dtack_o, 1'b1, "n_dtack after reset");
		check_level(lanes_oe_o, 1'b0, "lane enable after reset");
	endtask

	// ------------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------------
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d clocks, a bus cycle never finished",
			WATCHDOG_CYCLES);
		stop_run();
	end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		logic [7:0]  cfg_offs [6];
		logic [7:0]  slot_idx [8];
		logic [31:0] r, wdat, rdat;
		logic [3:0]  be;
		int          k;
		cfg_offs = '{8'h00, 8'h04, 8'h08, 8'h10, 8'h14, 8'h18};
		nIORST = 1'b0;
		bus_in = '0;
		a_i = '0;
		fc_i = 2'b00;
		read_i = 1'b1;
		n_fcs_i = 1'b1;
		doe_i = 1'b0;
		n_ds_i = 4'hF;
		n_cfgin_i = 1'b0;
		sense_z3_i = 1'b1;
		apply_reset(1'b1);
		check_level(n_cfgout_o, 1'b1, "n_cfgout before config");

		// config ROM, nibble on top and ones below
		for (int i = 0; i < 6; i++) begin
			full_read({24'hFF0000, cfg_offs[i]}, 2'b01, 1'b1, rdat);
			check_nibble(rdat[31:28], ref_cfg_nibble(cfg_offs[i]), "config nibble");
			check_word({4'hF, rdat[27:0]}, 32'hFFFF_FFFF, "config filler bits");
		end

		// base write passes the chain on
		full_write(32'hFF00_0044, 2'b01, BASE_ADDR, 4'hF, 1'b1);
		check_level(n_cfgout_o, 1'b0, "n_cfgout after base write");
		full_read(32'hFF00_0000, 2'b01, 1'b0, rdat);
		full_read(BASE_ADDR, 2'b10, 1'b1, rdat);

		// known contents first, then masked writes
		for (int i = 0; i < 8; i++) begin
			slot_idx[i] = 8'(i * 29 + 3);
			wdat = next_rand();
			full_write(card_addr(slot_idx[i], 1'b0), 2'b01, wdat, 4'hF, 1'b1);
			model[slot_idx[i]] = wdat;
		end
		for (int i = 0; i < 12; i++) begin
			r = next_rand();
			k = int'(r % 8);
			be = rand_mask(next_rand());
			wdat = next_rand();
			full_write(card_addr(slot_idx[k], r[20]), 2'b10, wdat, be, 1'b1);
			model[slot_idx[k]] = merge_bytes(model[slot_idx[k]], wdat, be);
		end
		for (int i = 0; i < 8; i++) begin
			full_read(card_addr(slot_idx[i], i[0]), 2'b01, 1'b1, rdat);
			check_word(rdat, model[slot_idx[i]], "memory read");
		end

		// wrong FC, outside the window
		full_read(BASE_ADDR, 2'b00, 1'b0, rdat);
		full_read(BASE_ADDR, 2'b11, 1'b0, rdat);
		full_read(32'h8000_0000, 2'b01, 1'b0, rdat);

		// shut up path
		apply_reset(1'b1);
		full_write(32'hFF00_004C, 2'b01, 32'h0, 4'hF, 1'b1);
		check_level(n_cfgout_o, 1'b0, "n_cfgout after shut up");
		full_read(32'hFF00_0000, 2'b01, 1'b0, rdat);
		full_read(BASE_ADDR, 2'b01, 1'b0, rdat);

		// Zorro II backplane, chain passes straight through
		apply_reset(1'b0);
		@(posedge clk);
		#5;
		n_cfgin_i = 1'b1;
		@(posedge clk);
		#5;
		check_level(n_cfgout_o, 1'b1, "n_cfgout follows high n_cfgin");
		n_cfgin_i = 1'b0;
		@(posedge clk);
		#5;
		check_level(n_cfgout_o, 1'b0, "n_cfgout follows low n_cfgin");
		full_read(32'hFF00_0000, 2'b01, 1'b0, rdat);

		$display("Regression passed");
		$finish;
	end

endmodule

// File: z3_card_properties.sv
// checks assume the FSM's registered outputs; /FCS seen through the two-flop sync in the bus block
`timescale 1ns/1ps

module z3_card_properties import zorro_pkg::*; (
	input logic      clk,
	input logic      nIORST,
	input logic      fcs_act_i,
	input z3_cycle_t cyc_i,
	input logic      n_slave_i,
	input logic      n_dtack_i,
	input logic      lanes_oe_i
);

	// ------------------------------------------------------------------
	// bus output rules
	// ------------------------------------------------------------------

	// no acknowledge without slave, and slave already low the clock before
	dtack_needs_slave: assert property (@(posedge clk) disable iff (!nIORST)
		!n_dtack_i |-> (!n_slave_i && $past(!n_slave_i)))
		else $error("DTACK low without SLAVE held low before it");

	// read data stays on the lanes while the cycle is acknowledged
	oe_at_read_ack: assert property (@(posedge clk) disable iff (!nIORST)
		(!n_dtack_i && fcs_act_i && cyc_i.read) |-> lanes_oe_i)
		else $error("read acknowledged with the data lanes not driven");

	// one clock after /FCS is seen inactive the cycle is gone
	dtack_ends_with_fcs: assert property (@(posedge clk) disable iff (!nIORST)
		!fcs_act_i |=> n_dtack_i)
		else $error("DTACK still low after FCS went inactive");

	slave_ends_with_fcs: assert property (@(posedge clk) disable iff (!nIORST)
		!fcs_act_i |=> n_slave_i)
		else $error("SLAVE still low after FCS went inactive");

endmodule

bind z3_slave_fsm z3_card_properties z3_card_properties_inst (
	.clk(clk), .nIORST(nIORST), .fcs_act_i(fcs_act_i), .cyc_i(cyc_i),
	.n_slave_i(n_slave_o), .n_dtack_i(n_dtack_o), .lanes_oe_i(lanes_oe_o)
);

// File: z3_card_top.sv
// bus pins split into in, out and enable lanes; external pad logic builds the tristate
`timescale 1ns/1ps

module z3_card_top import zorro_pkg::*; #(
	parameter int RAM_WORDS_LOG2 = 8
) (
	input  logic       clk,
	input  logic       nIORST,
	input  z3_lanes_t  lanes_i,
	input  logic [7:2] a_i,
	input  logic [1:0] fc_i,
	input  logic       read_i,
	input  logic       n_fcs_i,
	input  logic       doe_i,
	input  logic [3:0] n_ds_i,
	input  logic       n_cfgin_i,
	input  logic       sense_z3_i,
	output z3_lanes_t  lanes_o,
	output logic       lanes_oe_o,
	output logic       n_slave_o,
	output logic       n_dtack_o,
	output logic       n_cfgout_o
);
	// sync to FSM
	logic        start, fcs_act, doe_s, card_hit, cfg_hit;
	logic [3:0]  ds_n_s;
	z3_cycle_t   cyc;
	// memory port
	mem_req_t    mem_req;
	logic        mem_ack;
	logic [31:0] mem_rdata;
	// autoconfig
	logic [3:0]  cfg_rdata;
	logic        cfg_wr, configured, active;
	logic [31:0] wdata;
	logic [15:0] base;

	// ------------------------------------------------------------------
	// submodules
	// ------------------------------------------------------------------
	z3_bus_sync z3_bus_sync_inst (
		.clk(clk), .nIORST(nIORST), .n_fcs_i(n_fcs_i), .doe_i(doe_i),
		.n_ds_i(n_ds_i), .read_i(read_i), .lanes_i(lanes_i), .a_i(a_i),
		.fc_i(fc_i), .configured_i(configured), .active_i(active), .base_i(base),
		.n_cfgin_i(n_cfgin_i), .start_o(start), .fcs_act_o(fcs_act), .doe_o(doe_s),
		.ds_n_o(ds_n_s), .cyc_o(cyc), .card_hit_o(card_hit), .cfg_hit_o(cfg_hit)
	);

	z3_slave_fsm #(.RAM_WORDS_LOG2(RAM_WORDS_LOG2)) z3_slave_fsm_inst (
		.clk(clk), .nIORST(nIORST), .start_i(start), .fcs_act_i(fcs_act),
		.doe_i(doe_s), .ds_n_i(ds_n_s), .cyc_i(cyc), .card_hit_i(card_hit),
		.cfg_hit_i(cfg_hit), .lanes_i(lanes_i), .mem_req_o(mem_req),
		.mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata), .cfg_rdata_i(cfg_rdata),
		.cfg_wr_o(cfg_wr), .wdata_o(wdata), .lanes_o(lanes_o),
		.lanes_oe_o(lanes_oe_o), .n_slave_o(n_slave_o), .n_dtack_o(n_dtack_o)
	);

	autocfg_regs autocfg_regs_inst (
		.clk(clk), .nIORST(nIORST), .cyc_i(cyc), .cfg_wr_i(cfg_wr), .wdata_i(wdata),
		.n_cfgin_i(n_cfgin_i), .sense_z3_i(sense_z3_i), .cfg_rdata_o(cfg_rdata),
		.base_o(base), .configured_o(configured), .active_o(active),
		.n_cfgout_o(n_cfgout_o)
	);

	card_ram #(.RAM_WORDS_LOG2(RAM_WORDS_LOG2)) card_ram_inst (
		.clk(clk), .nIORST(nIORST), .req_i(mem_req), .ack_o(mem_ack),
		.rdata_o(mem_rdata)
	);

endmodule

// File: card_ram.sv
// single-clock word RAM standing in for the SDRAM; contents undefined after power up
`timescale 1ns/1ps

module card_ram import zorro_pkg::*; #(
	parameter int RAM_WORDS_LOG2 = 8
) (
	input  logic        clk,
	input  logic        nIORST,
	input  mem_req_t    req_i,
	output logic        ack_o,
	output logic [31:0] rdata_o
);
	logic [31:0] mem [2**RAM_WORDS_LOG2];
	logic [RAM_WORDS_LOG2-1:0] addr;

	// upper index bits ignored, address wraps
	assign addr = req_i.idx[RAM_WORDS_LOG2-1:0];

	// ------------------------------------------------------------------
	// array with byte lanes
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (req_i.stb) begin
			// old data on a write strobe
			rdata_o <= mem[addr];
			if (req_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.be[b])
						mem[addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
				end
			end
		end
	end

	// ack one cycle after stb, always
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			ack_o <= 1'b0;
		else
			ack_o <= req_i.stb;
	end

endmodule

// File: autocfg_regs.sv
// decodes only the high nibble of each config register; base write takes data bits 31:16
`timescale 1ns/1ps

module autocfg_regs import zorro_pkg::*; import autocfg_pkg::*; (
	input  logic        clk,
	input  logic        nIORST,
	input  z3_cycle_t   cyc_i,
	input  logic        cfg_wr_i,
	input  logic [31:0] wdata_i,
	input  logic        n_cfgin_i,
	input  logic        sense_z3_i,
	output logic [3:0]  cfg_rdata_o,
	output logic [15:0] base_o,
	output logic        configured_o,
	output logic        active_o,
	output logic        n_cfgout_o
);
	logic [7:0] offset;
	logic [3:0] rom_nib;
	logic       shutup_q;

	// byte offset within the 64K config space
	assign offset = {cyc_i.addr[7:2], 2'b00};

	// ------------------------------------------------------------------
	// ROM read mux
	// ------------------------------------------------------------------
	always_comb begin
		unique case (offset)
			REG_TYPE:     rom_nib = CFG_TYPE_NIB;
			REG_PRODUCT:  rom_nib = CFG_PRODUCT_NIB;
			REG_FLAGS:    rom_nib = CFG_FLAGS_NIB;
			REG_MANUF_HI: rom_nib = CFG_MANUF_HI_NIB;
			REG_MANUF_LO: rom_nib = CFG_MANUF_LO_NIB;
			REG_SERIAL:   rom_nib = 4'h0;
			default:      rom_nib = 4'h0;
		endcase
	end

	// all registers but TYPE read back inverted
	assign cfg_rdata_o = (offset == REG_TYPE) ? rom_nib : ~rom_nib;

	// ------------------------------------------------------------------
	// base register and flags
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_o <= 16'h0000;
			configured_o <= 1'b0;
			shutup_q <= 1'b0;
		end else if (cfg_wr_i) begin
			// base write also configures the card
			if (offset == REG_BASE) begin
				base_o <= wdata_i[31:16];
				configured_o <= 1'b1;
			end
			if (offset == REG_SHUTUP)
				shutup_q <= 1'b1;
		end
	end

	// Zorro II backplane shuts the card down
	assign active_o = sense_z3_i && !shutup_q;

	// chain passes on once done, or straight through on Z2
	assign n_cfgout_o = sense_z3_i ? !(configured_o || shutup_q) : n_cfgin_i;

endmodule

// File: z3_slave_fsm.sv
// single transfer cycles only, no /MTACK and no timeout; master must hold /FCS until /DTACK
`timescale 1ns/1ps

module z3_slave_fsm import zorro_pkg::*; #(
	parameter int RAM_WORDS_LOG2 = 8
) (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        start_i,
	input  logic        fcs_act_i,
	input  logic        doe_i,
	input  logic [3:0]  ds_n_i,
	input  z3_cycle_t   cyc_i,
	input  logic        card_hit_i,
	input  logic        cfg_hit_i,
	input  z3_lanes_t   lanes_i,
	output mem_req_t    mem_req_o,
	input  logic        mem_ack_i,
	input  logic [31:0] mem_rdata_i,
	input  logic [3:0]  cfg_rdata_i,
	output logic        cfg_wr_o,
	output logic [31:0] wdata_o,
	output z3_lanes_t   lanes_o,
	output logic        lanes_oe_o,
	output logic        n_slave_o,
	output logic        n_dtack_o
);
	z3_state_e   state_q, state_d;
	logic        stb_q, cfg_wr_q;
	logic [31:0] wdata_q, rd_word_q;
	logic [3:0]  be_q;

	// ------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE:
				if (start_i && (card_hit_i || cfg_hit_i))
					state_d = MATCH;
			// wait for data time
			MATCH:
				if (doe_i)
					state_d = DATA;
			DATA:
				if (cyc_i.read)
					state_d = cfg_hit_i ? RD_SETTLE : RD_WAIT;
				else if (ds_n_i != 4'hF)
					state_d = WR_STB;
			WR_STB:
				state_d = WR_WAIT;
			// config write takes one cycle
			WR_WAIT:
				if (cfg_hit_i || mem_ack_i)
					state_d = DTACK;
			RD_WAIT:
				if (mem_ack_i)
					state_d = RD_SETTLE;
			RD_SETTLE:
				state_d = DTACK;
			// held until /FCS goes away
			DTACK:
				state_d = DTACK;
		endcase
		// master ended the cycle
		if (state_q != IDLE && !fcs_act_i)
			state_d = IDLE;
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q <= IDLE;
			n_slave_o <= 1'b1;
			n_dtack_o <= 1'b1;
			stb_q <= 1'b0;
			cfg_wr_q <= 1'b0;
		end else begin
			state_q <= state_d;
			n_slave_o <= (state_d == IDLE);
			n_dtack_o <= (state_d != DTACK);
			// one-cycle pulses on leaving DATA or WR_STB
			stb_q <= (state_q == DATA && state_d == RD_WAIT) ||
				(state_q == WR_STB && state_d == WR_WAIT && card_hit_i);
			cfg_wr_q <= state_q == WR_STB && state_d == WR_WAIT && cfg_hit_i;
		end
	end

	// write data and read word, lanes swizzled to D31..D0
	always_ff @(posedge clk) begin
		if (state_q == WR_STB) begin
			wdata_q <= {lanes_i.ad[31:24], lanes_i.sd, lanes_i.ad[23:8]};
			be_q <= ~ds_n_i;
		end else if (state_q == DATA && cyc_i.read) begin
			be_q <= 4'hF;
			// nibble in D31..D28, rest reads as ones
			if (cfg_hit_i)
				rd_word_q <= {cfg_rdata_i, 28'hFFFFFFF};
		end else if (state_q == RD_WAIT && mem_ack_i) begin
			rd_word_q <= mem_rdata_i;
		end
	end

	// word index wraps at the memory size
	always_comb begin
		mem_req_o.idx = {{(30 - RAM_WORDS_LOG2){1'b0}}, cyc_i.addr[RAM_WORDS_LOG2+1:2]};
		mem_req_o.wdata = wdata_q;
		mem_req_o.be = be_q;
		mem_req_o.we = !cyc_i.read;
		mem_req_o.stb = stb_q;
	end

	assign cfg_wr_o = cfg_wr_q;
	assign wdata_o = wdata_q;
	assign lanes_o.ad = {rd_word_q[31:24], rd_word_q[15:0]};
	assign lanes_o.sd = rd_word_q[23:16];
	// drive only while selected, DOE up and reading
	assign lanes_oe_o = !n_slave_o && doe_i && cyc_i.read;

endmodule

// File: z3_bus_sync.sv
// address and FC must be stable for 4 clk after /FCS falls; strobes are async to clk
`timescale 1ns/1ps

module z3_bus_sync import zorro_pkg::*; (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        n_fcs_i,
	input  logic        doe_i,
	input  logic [3:0]  n_ds_i,
	input  logic        read_i,
	input  z3_lanes_t   lanes_i,
	input  logic [7:2]  a_i,
	input  logic [1:0]  fc_i,
	input  logic        configured_i,
	input  logic        active_i,
	input  logic [15:0] base_i,
	input  logic        n_cfgin_i,
	output logic        start_o,
	output logic        fcs_act_o,
	output logic        doe_o,
	output logic [3:0]  ds_n_o,
	output z3_cycle_t   cyc_o,
	output logic        card_hit_o,
	output logic        cfg_hit_o
);
	logic [2:0] fcs_sync;
	logic [1:0] doe_sync;
	logic [3:0] ds_sync0, ds_sync1;
	logic       start_d, fc_ok, card_hit_d, cfg_hit_d;

	// two flops plus one more for the edge
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_sync <= 3'b111;
			doe_sync <= 2'b00;
			ds_sync0 <= 4'hF;
			ds_sync1 <= 4'hF;
			start_o <= 1'b0;
			card_hit_o <= 1'b0;
			cfg_hit_o <= 1'b0;
		end else begin
			fcs_sync <= {fcs_sync[1:0], n_fcs_i};
			doe_sync <= {doe_sync[0], doe_i};
			ds_sync0 <= n_ds_i;
			ds_sync1 <= ds_sync0;
			start_o <= start_d;
			// hits hold for the whole cycle
			if (start_d) begin
				card_hit_o <= card_hit_d;
				cfg_hit_o <= cfg_hit_d;
			end
		end
	end

	// address latch, replaces the negedge /FCS latch
	always_ff @(posedge clk) begin
		if (start_d)
			cyc_o <= '{addr: {lanes_i.ad, a_i}, fc: fc_i, read: read_i};
	end

	// synchronized /FCS just went low
	assign start_d = !fcs_sync[1] && fcs_sync[2];
	// user data or program space only
	assign fc_ok = fc_i[0] ^ fc_i[1];
	assign card_hit_d = fc_ok && configured_i && active_i &&
		(lanes_i.ad[31:32-CARD_MATCH_BITS] == base_i[15:16-CARD_MATCH_BITS]);
	assign cfg_hit_d = fc_ok && !configured_i && active_i && !n_cfgin_i &&
		(lanes_i.ad[31:16] == CFG_SPACE_HI);

	assign fcs_act_o = !fcs_sync[1];
	assign doe_o = doe_sync[1];
	assign ds_n_o = ds_sync1;

endmodule

// File: autocfg_pkg.sv
// ROM contents describe one fixed Z3 memory card; offsets are byte offsets in config space
package autocfg_pkg;

	// ------------------------------------------------------------------
	// config register offsets
	// ------------------------------------------------------------------

	// only the high nibble of each register is decoded
	typedef enum logic [7:0] {
		REG_TYPE     = 8'h00,
		REG_PRODUCT  = 8'h04,
		REG_FLAGS    = 8'h08,
		REG_MANUF_HI = 8'h10,
		REG_MANUF_LO = 8'h14,
		REG_SERIAL   = 8'h18,
		REG_BASE     = 8'h44,
		REG_SHUTUP   = 8'h4C
	} cfg_reg_e;

	// ------------------------------------------------------------------
	// ROM nibbles, stored true
	// ------------------------------------------------------------------

	// type 10xx, Z3 board
	parameter logic [3:0] CFG_TYPE_NIB = 4'h8;

	// product number nibble
	parameter logic [3:0] CFG_PRODUCT_NIB = 4'h3;

	// flags, memory space with size extension
	parameter logic [3:0] CFG_FLAGS_NIB = 4'h3;

	// manufacturer id, high and low nibble
	parameter logic [3:0] CFG_MANUF_HI_NIB = 4'hA;
	parameter logic [3:0] CFG_MANUF_LO_NIB = 4'hB;

endpackage

// File: zorro_pkg.sv
// bus lane layout, latched cycle and memory request types for a single-clock Zorro III slave
package zorro_pkg;

	// ------------------------------------------------------------------
	// bus lanes
	// ------------------------------------------------------------------

	// ad carries A31..A8 in address time and D31..D24 / D15..D0 in data time
	typedef struct packed {
		logic [31:8] ad;
		logic [7:0]  sd;
	} z3_lanes_t;

	// cycle latched at the falling full cycle strobe
	typedef struct packed {
		logic [31:2] addr;
		logic [1:0]  fc;
		logic        read;
	} z3_cycle_t;

	// request to the card memory
	// be bit 3 strobes word bits 31:24
	typedef struct packed {
		logic [29:0] idx;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        we;
		logic        stb;
	} mem_req_t;

	// slave cycle states
	typedef enum logic [2:0] {
		IDLE,
		MATCH,
		DATA,
		WR_STB,
		WR_WAIT,
		RD_WAIT,
		RD_SETTLE,
		DTACK
	} z3_state_e;

	// config space sits at FF00xxxx on Zorro III
	parameter logic [15:0] CFG_SPACE_HI = 16'hFF00;
	// 6 address bits against the base, 64 MB window
	parameter int CARD_MATCH_BITS = 6;

endpackage
